// ==== ftdi_245fifo.f ====
verilog/ftdi_fifo_pkg.sv
verilog/ftdi_stream_fifo.sv
verilog/ftdi_245fifo_fsm.sv
verilog/ftdi_245fifo_top.sv
verification/ftdi_245fifo_chk.sv
verification/tb_ftdi_245fifo.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and pass only when
# the simulation output holds the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_ftdi_245fifo \
    -f ftdi_245fifo.f -o sim_ftdi_245fifo &&
out=$(./obj_dir/sim_ftdi_245fifo +verilator+error+limit+100)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "No errors" && exit 0 || exit 1

// ==== verification/tb_ftdi_245fifo.sv ====
// ----------------------------------------------------------------------
// testbench for the 245-FIFO controller top level
// a behavioral chip model serves reads from a byte queue and records
// writes; a table of send and receive tests is applied in a loop
// and every byte is compared against start byte plus index
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_ftdi_245fifo;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int DRAIN_CYCLES = 8;
    localparam int NROWS        = 5;

    localparam logic [1:0] DIR_TX   = 2'd1;
    localparam logic [1:0] DIR_RX   = 2'd2;
    localparam logic [1:0] DIR_BOTH = 2'd3;

    typedef struct packed {
        logic [7:0] id;
        logic [1:0] dir;
        logic [7:0] count;
        logic [7:0] start;
        logic       busy;
        logic [7:0] rdy_pat;
        logic [7:0] rdy_hold;
    } row_t;

    // id, direction, bytes, start byte, busy txe_n, ready pattern, ready hold-off
    localparam row_t ROWS [NROWS] = '{
        '{8'd2, DIR_TX,   8'd24, 8'h10, 1'b0, 8'hFF,       8'd0},
        '{8'd3, DIR_RX,   8'd24, 8'h40, 1'b0, 8'hFF,       8'd0},
        '{8'd4, DIR_RX,   8'd40, 8'h80, 1'b0, 8'hFF,       8'd60},
        '{8'd5, DIR_TX,   8'd32, 8'hC0, 1'b1, 8'hFF,       8'd0},
        '{8'd6, DIR_BOTH, 8'd24, 8'hF0, 1'b0, 8'b11010111, 8'd0}
    };

    logic       clk;
    logic       rst_n;
    logic       tx_tvalid;
    logic       tx_tready;
    logic [7:0] tx_tdata;
    logic       rx_tvalid;
    logic       rx_tready;
    logic [7:0] rx_tdata;
    logic       ftdi_rxf_n;
    logic       ftdi_txe_n;
    logic       ftdi_oe_n;
    logic       ftdi_rd_n;
    logic       ftdi_wr_n;
    logic [7:0] ftdi_din;
    logic [7:0] ftdi_dout;
    logic       ftdi_data_oe;

    // chip model state
    logic [7:0] chip_rd_q [$];
    integer     seed = 77;
    int         busy_left = 0;
    logic       busy_level = 1'b0;

    int err_count   = 0;
    int check_count = 0;
    int tests_run   = 0;

    ftdi_245fifo_top dut0 (
        .i_ftdi_clk     (clk),
        .i_rst_n        (rst_n),
        .i_tx_tvalid    (tx_tvalid),
        .o_tx_tready    (tx_tready),
        .i_tx_tdata     (tx_tdata),
        .o_rx_tvalid    (rx_tvalid),
        .i_rx_tready    (rx_tready),
        .o_rx_tdata     (rx_tdata),
        .i_ftdi_rxf_n   (ftdi_rxf_n),
        .i_ftdi_txe_n   (ftdi_txe_n),
        .o_ftdi_oe_n    (ftdi_oe_n),
        .o_ftdi_rd_n    (ftdi_rd_n),
        .o_ftdi_wr_n    (ftdi_wr_n),
        .i_ftdi_data    (ftdi_din),
        .o_ftdi_data    (ftdi_dout),
        .o_ftdi_data_oe (ftdi_data_oe)
    );

    bind ftdi_245fifo_top ftdi_245fifo_chk chk0 (
        .i_ftdi_clk (i_ftdi_clk),
        .i_rst_n    (i_rst_n),
        .i_oe_n     (o_ftdi_oe_n),
        .i_rd_n     (o_ftdi_rd_n),
        .i_wr_n     (o_ftdi_wr_n),
        .i_data_oe  (o_ftdi_data_oe)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    task automatic check_value(input logic [7:0] got, input logic [7:0] exp,
                               input string what);
        check_count++;
        if (got !== exp) begin
            $display("[FAIL] %0d ns: %s is %02h, expected %02h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic report_extra(input int id, input string where);
        $display("test %0d: %s carried a byte beyond the expected count", id, where);
        err_count++;
    endtask

    function automatic string dir_name(input logic [1:0] dir);
        case (dir)
            DIR_TX:  return "send";
            DIR_RX:  return "receive";
            default: return "both";
        endcase
    endfunction

    function automatic int total_bytes();
        int sum;
        sum = 0;
        for (int i = 0; i < NROWS; i++) sum += int'(ROWS[i].count);
        return sum;
    endfunction

    // chip pins for the coming cycle
    // txe_n goes busy in random stretches
    task automatic drive_chip(input logic busy);
        if (busy) begin
            if (busy_left == 0) begin
                busy_level = (($random(seed) & 1) != 0);
                busy_left  = 1 + ($random(seed) & 7);
            end
            busy_left--;
            ftdi_txe_n = busy_level;
        end else begin
            ftdi_txe_n = 1'b0;
        end
        ftdi_rxf_n = (chip_rd_q.size() == 0);
        ftdi_din   = (chip_rd_q.size() != 0) ? chip_rd_q[0] : 8'h00;
    endtask

    // ------------------------------------------------------------------
    // one table row
    // ------------------------------------------------------------------
    task automatic run_row(input row_t r);
        int tx_n;
        int rx_n;
        int tx_acc;
        int tx_seen;
        int rx_seen;
        int cyc;
        int idle;
        int errs_at_start;
        tx_n    = r.dir[0] ? int'(r.count) : 0;
        rx_n    = r.dir[1] ? int'(r.count) : 0;
        tx_acc  = 0;
        tx_seen = 0;
        rx_seen = 0;
        cyc     = 0;
        idle    = 0;
        errs_at_start = err_count;
        for (int k = 0; k < rx_n; k++) chip_rd_q.push_back(8'(r.start + k));

        while (idle < DRAIN_CYCLES) begin
            @(posedge clk);
            // sample at the edge before the DUT registers move
            if (tx_tvalid && tx_tready) tx_acc++;
            if (rx_tvalid && rx_tready) begin
                if (rx_seen < rx_n) begin
                    check_value(rx_tdata, 8'(r.start + rx_seen), "receive stream byte");
                end else begin
                    report_extra(r.id, "receive stream");
                end
                rx_seen++;
            end
            if (!ftdi_wr_n && !ftdi_txe_n) begin
                if (tx_seen < tx_n) begin
                    check_value(ftdi_dout, 8'(r.start + tx_seen), "chip write byte");
                end else begin
                    report_extra(r.id, "chip write bus");
                end
                tx_seen++;
            end
            // the chip drives the bus whenever oe_n is low
            if (!ftdi_oe_n) begin
                check_value(8'(ftdi_data_oe), 8'd0, "data_oe while oe_n is low");
            end
            if (!ftdi_rd_n && !ftdi_rxf_n) void'(chip_rd_q.pop_front());

            #1;
            tx_tvalid = (tx_acc < tx_n);
            tx_tdata  = 8'(r.start + tx_acc);
            rx_tready = ((cyc >= int'(r.rdy_hold)) && r.rdy_pat[3'(cyc)]) ||
                        (rx_seen >= rx_n);
            drive_chip(r.busy);
            cyc++;
            if (tx_seen >= tx_n && rx_seen >= rx_n) idle++;
        end
        $display("test %0d %s: %0d bytes written to chip, %0d received, %0d errors",
                 r.id, dir_name(r.dir), tx_seen, rx_seen, err_count - errs_at_start);
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin : main
        rst_n      = 1'b0;
        tx_tvalid  = 1'b0;
        tx_tdata   = 8'h00;
        rx_tready  = 1'b0;
        ftdi_rxf_n = 1'b1;
        ftdi_txe_n = 1'b1;
        ftdi_din   = 8'h00;

        repeat (RESET_CYCLES) @(posedge clk);
        check_value(8'(ftdi_oe_n), 8'd1, "oe_n after reset");
        check_value(8'(ftdi_rd_n), 8'd1, "rd_n after reset");
        check_value(8'(ftdi_wr_n), 8'd1, "wr_n after reset");
        check_value(8'(ftdi_data_oe), 8'd0, "data_oe after reset");
        check_value(8'(rx_tvalid), 8'd0, "rx_tvalid after reset");
        check_value(8'(tx_tready), 8'd0, "tx_tready after reset");
        $display("test 1 reset state: %0d errors", err_count);
        tests_run = 1;

        #1;
        rst_n      = 1'b1;
        ftdi_txe_n = 1'b0;
        rx_tready  = 1'b1;

        for (int i = 0; i < NROWS; i++) begin
            run_row(ROWS[i]);
            tests_run++;
        end

        if (dut0.chk0.fail_count != 0) begin
            $display("bound checker saw %0d protocol violations", dut0.chk0.fail_count);
            err_count += dut0.chk0.fail_count;
        end
        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, check_count,
                 err_count);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // generous budget of 20 cycles per byte on top of reset
    initial begin : watchdog
        int limit;
        limit = RESET_CYCLES + 20 * total_bytes();
        repeat (limit) @(posedge clk);
        $display("timeout: run stopped after %0d cycles with transfers still pending", limit);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/ftdi_245fifo_chk.sv ====
// ----------------------------------------------------------------------
// protocol checker for the 245-FIFO chip pins, bound into the top level
// flags bus fights, writes without bus drive, reads without oe_n and
// strobes that leave their idle level while reset is held
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ftdi_245fifo_chk (
    input logic i_ftdi_clk,
    input logic i_rst_n,
    input logic i_oe_n,
    input logic i_rd_n,
    input logic i_wr_n,
    input logic i_data_oe
);

    int   fail_count = 0;
    logic rst_seen   = 1'b0;

    // strobes hold their reset level only from the second reset edge on
    always @(posedge i_ftdi_clk) begin
        rst_seen <= !i_rst_n;
    end

    a_no_rd_wr: assert property (@(posedge i_ftdi_clk) disable iff (!i_rst_n)
        !(!i_rd_n && !i_wr_n))
        else begin
            $error("rd_n and wr_n are low together");
            fail_count++;
        end

    a_wr_driven: assert property (@(posedge i_ftdi_clk) disable iff (!i_rst_n)
        !(!i_wr_n && !i_data_oe))
        else begin
            $error("wr_n is low while the data bus is not driven");
            fail_count++;
        end

    a_rd_oe: assert property (@(posedge i_ftdi_clk) disable iff (!i_rst_n)
        !(!i_rd_n && i_oe_n))
        else begin
            $error("rd_n is low while oe_n is high");
            fail_count++;
        end

    a_reset_idle: assert property (@(posedge i_ftdi_clk)
        (!i_rst_n && rst_seen) |-> (i_oe_n && i_rd_n && i_wr_n))
        else begin
            $error("a chip strobe is low during reset");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== verilog/ftdi_245fifo_top.sv ====
// ----------------------------------------------------------------------
// top level of the 245-FIFO controller, everything on the chip clock
// send path: user stream -> send buffer -> state machine -> chip
// receive path: chip -> state machine -> receive buffer -> user stream
// o_ftdi_data_oe enables the external tri-state pad on the data bus
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ftdi_245fifo_top import ftdi_fifo_pkg::*; (
    input  logic       i_ftdi_clk,
    input  logic       i_rst_n,
    // user send stream, FPGA to PC
    input  logic       i_tx_tvalid,
    output logic       o_tx_tready,
    input  ftdi_byte_t i_tx_tdata,
    // user receive stream, PC to FPGA
    output logic       o_rx_tvalid,
    input  logic       i_rx_tready,
    output ftdi_byte_t o_rx_tdata,
    // chip pins
    input  logic       i_ftdi_rxf_n,
    input  logic       i_ftdi_txe_n,
    output logic       o_ftdi_oe_n,
    output logic       o_ftdi_rd_n,
    output logic       o_ftdi_wr_n,
    input  ftdi_byte_t i_ftdi_data,
    output ftdi_byte_t o_ftdi_data,
    output logic       o_ftdi_data_oe
);

    logic       tx_valid;
    ftdi_byte_t tx_data;
    logic       tx_ready;
    logic       rx_wr_en;
    ftdi_byte_t rx_wr_data;
    logic       rx_afull;

    // send buffer, almost-full not needed on this side
    ftdi_stream_fifo #(
        .EA            (TX_EA)
    ) u_tx_fifo (
        .i_ftdi_clk    (i_ftdi_clk),
        .i_rst_n       (i_rst_n),
        .i_wr_valid    (i_tx_tvalid),
        .i_wr_data     (i_tx_tdata),
        .o_wr_ready    (o_tx_tready),
        .o_rd_valid    (tx_valid),
        .o_rd_data     (tx_data),
        .i_rd_ready    (tx_ready),
        .o_almost_full ()
    );

    ftdi_245fifo_fsm u_fsm (
        .i_ftdi_clk     (i_ftdi_clk),
        .i_rst_n        (i_rst_n),
        .i_tx_valid     (tx_valid),
        .i_tx_data      (tx_data),
        .o_tx_ready     (tx_ready),
        .o_rx_wr_en     (rx_wr_en),
        .o_rx_wr_data   (rx_wr_data),
        .i_rx_afull     (rx_afull),
        .i_ftdi_rxf_n   (i_ftdi_rxf_n),
        .i_ftdi_txe_n   (i_ftdi_txe_n),
        .o_ftdi_oe_n    (o_ftdi_oe_n),
        .o_ftdi_rd_n    (o_ftdi_rd_n),
        .o_ftdi_wr_n    (o_ftdi_wr_n),
        .i_ftdi_data    (i_ftdi_data),
        .o_ftdi_data    (o_ftdi_data),
        .o_ftdi_data_oe (o_ftdi_data_oe)
    );

    // receive buffer, the almost-full margin replaces a write ready
    ftdi_stream_fifo #(
        .EA            (RX_EA)
    ) u_rx_fifo (
        .i_ftdi_clk    (i_ftdi_clk),
        .i_rst_n       (i_rst_n),
        .i_wr_valid    (rx_wr_en),
        .i_wr_data     (rx_wr_data),
        .o_wr_ready    (),
        .o_rd_valid    (o_rx_tvalid),
        .o_rd_data     (o_rx_tdata),
        .i_rd_ready    (i_rx_tready),
        .o_almost_full (rx_afull)
    );

endmodule

`default_nettype wire

// ==== verilog/ftdi_245fifo_fsm.sv ====
// ----------------------------------------------------------------------
// 245 synchronous FIFO mode state machine for an 8-bit FTDI chip
// reads have priority over writes; a read burst opens with one
// oe_n turnaround cycle and closes through ST_RX_END
// all chip strobes and the data bus drive are registered
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ftdi_245fifo_fsm import ftdi_fifo_pkg::*; (
    input  logic       i_ftdi_clk,
    input  logic       i_rst_n,
    // send buffer side
    input  logic       i_tx_valid,
    input  ftdi_byte_t i_tx_data,
    output logic       o_tx_ready,
    // receive buffer side
    output logic       o_rx_wr_en,
    output ftdi_byte_t o_rx_wr_data,
    input  logic       i_rx_afull,
    // chip pins
    input  logic       i_ftdi_rxf_n,
    input  logic       i_ftdi_txe_n,
    output logic       o_ftdi_oe_n,
    output logic       o_ftdi_rd_n,
    output logic       o_ftdi_wr_n,
    input  ftdi_byte_t i_ftdi_data,
    output ftdi_byte_t o_ftdi_data,
    output logic       o_ftdi_data_oe
);

    fsm_state_e state_q;
    logic       want_rx;
    logic       wr_accept;
    logic       hold_free;
    logic       rd_edge;
    logic       tx_load;

    // ------------------------------------------------------------------
    // edge qualifiers
    // ------------------------------------------------------------------
    // chip has data and the receive buffer still has room
    assign want_rx   = !i_ftdi_rxf_n && !i_rx_afull;
    // this edge hands the held byte to the chip
    assign wr_accept = !o_ftdi_wr_n && !i_ftdi_txe_n;
    // wr_n low means a byte is held in the output register
    assign hold_free = o_ftdi_wr_n || wr_accept;
    // this edge takes a byte from the chip
    assign rd_edge   = !o_ftdi_rd_n && !i_ftdi_rxf_n;

    // pop the send buffer only when the output register reloads
    always_comb begin
        case (state_q)
            ST_IDLE:     o_tx_ready = !want_rx && !i_ftdi_txe_n;
            ST_TX_WRITE: o_tx_ready = hold_free && !want_rx;
            default:     o_tx_ready = 1'b0;
        endcase
    end

    assign tx_load = o_tx_ready && i_tx_valid;

    // ------------------------------------------------------------------
    // state and strobes
    // ------------------------------------------------------------------
    always_ff @(posedge i_ftdi_clk) begin
        if (!i_rst_n) begin
            state_q        <= ST_IDLE;
            o_ftdi_oe_n    <= 1'b1;
            o_ftdi_rd_n    <= 1'b1;
            o_ftdi_wr_n    <= 1'b1;
            o_ftdi_data_oe <= 1'b0;
            o_rx_wr_en     <= 1'b0;
        end else begin
            // every read edge lands in the receive buffer one cycle later
            o_rx_wr_en <= rd_edge;

            case (state_q)
                ST_IDLE: begin
                    if (want_rx) begin
                        o_ftdi_oe_n <= 1'b0;
                        state_q     <= ST_RX_OE;
                    end else if (tx_load) begin
                        o_ftdi_wr_n    <= 1'b0;
                        o_ftdi_data_oe <= 1'b1;
                        state_q        <= ST_TX_WRITE;
                    end
                end

                // turnaround: chip drives the bus before rd_n falls
                ST_RX_OE: begin
                    if (i_ftdi_rxf_n || i_rx_afull) begin
                        state_q <= ST_RX_END;
                    end else begin
                        o_ftdi_rd_n <= 1'b0;
                        state_q     <= ST_RX_READ;
                    end
                end

                ST_RX_READ: begin
                    if (i_ftdi_rxf_n || i_rx_afull) begin
                        o_ftdi_rd_n <= 1'b1;
                        state_q     <= ST_RX_END;
                    end
                end

                // release the bus before anything else drives it
                ST_RX_END: begin
                    o_ftdi_oe_n <= 1'b1;
                    state_q     <= ST_IDLE;
                end

                ST_TX_WRITE: begin
                    if (tx_load) begin
                        o_ftdi_wr_n <= 1'b0;
                    end else if (hold_free) begin
                        // burst over, or a read is waiting
                        o_ftdi_wr_n    <= 1'b1;
                        o_ftdi_data_oe <= 1'b0;
                        state_q        <= ST_IDLE;
                    end
                end

                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------
    // data registers
    // ------------------------------------------------------------------
    always_ff @(posedge i_ftdi_clk) begin
        if (rd_edge) o_rx_wr_data <= i_ftdi_data;
        // held byte stays put while txe_n is high
        if (tx_load) o_ftdi_data <= i_tx_data;
    end

endmodule

`default_nettype wire

// ==== verilog/ftdi_stream_fifo.sv ====
// ----------------------------------------------------------------------
// synchronous byte FIFO with valid/ready on both sides
// holds 2^EA bytes in a circular buffer plus one output register
// almost-full is registered and used to throttle chip reads
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ftdi_stream_fifo import ftdi_fifo_pkg::*; #(
    parameter int EA = 4
) (
    input  logic       i_ftdi_clk,
    input  logic       i_rst_n,
    input  logic       i_wr_valid,
    input  ftdi_byte_t i_wr_data,
    output logic       o_wr_ready,
    output logic       o_rd_valid,
    output ftdi_byte_t o_rd_data,
    input  logic       i_rd_ready,
    output logic       o_almost_full
);

    localparam int DEPTH = 1 << EA;

    ftdi_byte_t    mem [DEPTH];
    logic [EA-1:0] wr_ptr;
    logic [EA-1:0] rd_ptr;
    logic [EA:0]   count;
    logic [EA:0]   count_next;
    logic          wr_fire;
    logic          out_load;
    logic          mem_pop;
    logic          bypass;
    logic          mem_push;

    assign wr_fire  = i_wr_valid && o_wr_ready;
    // output register takes a new byte when empty or being drained
    assign out_load = !o_rd_valid || i_rd_ready;
    assign mem_pop  = out_load && (count != '0);
    // empty buffer, so a fresh byte goes straight to the output register
    assign bypass   = out_load && (count == '0) && wr_fire;
    assign mem_push = wr_fire && !bypass;

    always_comb begin
        count_next = count;
        if (mem_push && !mem_pop) begin
            count_next = count + 1'b1;
        end else if (!mem_push && mem_pop) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge i_ftdi_clk) begin
        if (!i_rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            o_rd_valid    <= 1'b0;
            o_wr_ready    <= 1'b0;
            o_almost_full <= 1'b0;
        end else begin
            if (mem_push) wr_ptr <= wr_ptr + 1'b1;
            if (mem_pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count_next;
            if (out_load) o_rd_valid <= (count != '0) || wr_fire;
            o_wr_ready    <= (int'(count_next) < DEPTH);
            o_almost_full <= (DEPTH - int'(count_next)) <= RX_AFULL_MARGIN;
        end
    end

    // storage and output data
    always_ff @(posedge i_ftdi_clk) begin
        if (mem_push) mem[wr_ptr] <= i_wr_data;
        if (mem_pop) begin
            o_rd_data <= mem[rd_ptr];
        end else if (bypass) begin
            o_rd_data <= i_wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ftdi_fifo_pkg.sv ====
// ----------------------------------------------------------------------
// shared constants and types for the FT232H-class 245-FIFO controller
// imported by the stream FIFO, the chip state machine and the top level
// ----------------------------------------------------------------------
`default_nettype none

package ftdi_fifo_pkg;

    // ------------------------------------------------------------------
    // widths and depths
    // ------------------------------------------------------------------
    // chip bus and both user streams are one byte wide
    localparam int CHIP_DW = 8;

    // buffer depth exponents, 16 entries each
    localparam int TX_EA = 4;
    localparam int RX_EA = 4;

    // free entries left when almost-full asserts, covers bytes that
    // still land after rd_n rises
    localparam int RX_AFULL_MARGIN = 4;

    // ------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------
    typedef logic [CHIP_DW-1:0] ftdi_byte_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RX_OE,
        ST_RX_READ,
        ST_TX_WRITE,
        ST_RX_END
    } fsm_state_e;

endpackage

`default_nettype wire
